/* rtl/stopwatch_pkg.sv */
package stopwatch_pkg;

  ////////////////////
  // Display and digit types
  ////////////////////

  // One decimal digit
  typedef logic [3:0] bcd_t;

  // Segments a..g, active low, bit 0 is a
  typedef logic [6:0] seg_t;

  // Digit enables, active low, bit 3 is leftmost
  typedef logic [3:0] anode_t;

  // Digit currently being scanned
  typedef logic [1:0] scan_idx_t;

  ////////////////////
  // Digit limits
  ////////////////////

  localparam int DIGIT_COUNT = 4;

  localparam bcd_t DEC_MAX = 4'd9;

  // Tens of seconds only reach 5
  localparam bcd_t SEC_TENS_MAX = 4'd5;

endpackage

/* rtl/tick_divider.sv */
`timescale 1ns/1ps

module tick_divider #(
  parameter int TICK_DIV = 5_000_000
) (
  input  logic clock,
  input  logic arst_n,
  input  logic enable,
  input  logic clr,
  output logic tick
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CNT_W-1:0] count;
  logic             terminal;

  assign terminal = (count == CNT_W'(TICK_DIV - 1));
  assign tick     = enable & terminal;

  // Count is held while paused, so the remainder survives
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (clr) begin
      count <= '0;
    end else if (enable) begin
      if (terminal) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  tick_only_when_enabled: assert property (
    @(posedge clock) disable iff (!arst_n) !enable |-> !tick
  );

endmodule

/* rtl/bcd_digit_counter.sv */
`timescale 1ns/1ps

module bcd_digit_counter import stopwatch_pkg::*; #(
  parameter bcd_t MAX = DEC_MAX
) (
  input  logic clock,
  input  logic arst_n,
  input  logic clr,
  input  logic step,
  input  logic up,
  output bcd_t value,
  output logic wrap
);

  logic at_limit;

  // Limit depends on direction
  assign at_limit = up ? (value == MAX) : (value == '0);

  // Combinational so a carry ripples within one edge
  assign wrap = step & at_limit;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      value <= '0;
    end else if (clr) begin
      value <= '0;
    end else if (step) begin
      if (up) begin
        if (at_limit) begin
          value <= '0;
        end else begin
          value <= bcd_t'(value + 1'b1);
        end
      end else begin
        if (at_limit) begin
          value <= MAX;
        end else begin
          value <= bcd_t'(value - 1'b1);
        end
      end
    end
  end

  value_in_range: assert property (
    @(posedge clock) disable iff (!arst_n) value <= MAX
  );

  // A wrap always lands on the opposite limit
  wrap_lands_on_limit: assert property (
    @(posedge clock) disable iff (!arst_n)
    (wrap && !clr) |=> (value == ($past(up) ? '0 : MAX))
  );

endmodule

/* rtl/stopwatch_core.sv */
`timescale 1ns/1ps

module stopwatch_core import stopwatch_pkg::*; (
  input  logic clock,
  input  logic arst_n,
  input  logic clr,
  input  logic tick,
  input  logic up,
  output bcd_t min_digit,
  output bcd_t sec_tens,
  output bcd_t sec_units,
  output bcd_t tenths
);

  logic tenths_wrap;
  logic units_wrap;
  logic tens_wrap;

  ////////////////////
  // M:S S.T chain, right to left
  ////////////////////

  bcd_digit_counter #(.MAX(DEC_MAX)) u_tenths (
    .clock  (clock),
    .arst_n (arst_n),
    .clr    (clr),
    .step   (tick),
    .up     (up),
    .value  (tenths),
    .wrap   (tenths_wrap)
  );

  bcd_digit_counter #(.MAX(DEC_MAX)) u_sec_units (
    .clock  (clock),
    .arst_n (arst_n),
    .clr    (clr),
    .step   (tenths_wrap),
    .up     (up),
    .value  (sec_units),
    .wrap   (units_wrap)
  );

  bcd_digit_counter #(.MAX(SEC_TENS_MAX)) u_sec_tens (
    .clock  (clock),
    .arst_n (arst_n),
    .clr    (clr),
    .step   (units_wrap),
    .up     (up),
    .value  (sec_tens),
    .wrap   (tens_wrap)
  );

  // Minutes wrap unused, rolls over modulo 6000 tenths
  bcd_digit_counter #(.MAX(DEC_MAX)) u_min (
    .clock  (clock),
    .arst_n (arst_n),
    .clr    (clr),
    .step   (tens_wrap),
    .up     (up),
    .value  (min_digit),
    .wrap   ()
  );

endmodule

/* rtl/seg7_decoder.sv */
`timescale 1ns/1ps

module seg7_decoder import stopwatch_pkg::*; (
  input  bcd_t digit,
  output seg_t segment
);

  localparam seg_t SEG_BLANK = 7'b111_1111;

  // Bit order g f e d c b a, low lights the segment
  always_comb begin
    case (digit)
      4'd0:    segment = 7'b100_0000;
      4'd1:    segment = 7'b111_1001;
      4'd2:    segment = 7'b010_0100;
      4'd3:    segment = 7'b011_0000;
      4'd4:    segment = 7'b001_1001;
      4'd5:    segment = 7'b001_0010;
      4'd6:    segment = 7'b000_0010;
      4'd7:    segment = 7'b111_1000;
      4'd8:    segment = 7'b000_0000;
      4'd9:    segment = 7'b001_0000;
      // Non-BCD codes stay dark
      default: segment = SEG_BLANK;
    endcase
  end

endmodule

/* rtl/display_scan.sv */
`timescale 1ns/1ps

module display_scan import stopwatch_pkg::*; #(
  parameter int SCAN_DIV = 50_000
) (
  input  logic   clock,
  input  logic   arst_n,
  input  bcd_t   min_digit,
  input  bcd_t   sec_tens,
  input  bcd_t   sec_units,
  input  bcd_t   tenths,
  output anode_t anode,
  output bcd_t   scan_digit
);

  localparam int DWELL_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [DWELL_W-1:0] dwell;
  logic               dwell_done;
  scan_idx_t          scan_idx;

  assign dwell_done = (dwell == DWELL_W'(SCAN_DIV - 1));

  ////////////////////
  // Dwell and scan index
  ////////////////////

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      dwell    <= '0;
      scan_idx <= '0;
    end else if (dwell_done) begin
      dwell <= '0;
      if (scan_idx == scan_idx_t'(DIGIT_COUNT - 1)) begin
        scan_idx <= '0;
      end else begin
        scan_idx <= scan_idx + 1'b1;
      end
    end else begin
      dwell <= dwell + 1'b1;
    end
  end

  // Anode and digit from the same index, always in step
  always_comb begin
    case (scan_idx)
      2'd0:    begin anode = 4'b0111; scan_digit = min_digit; end
      2'd1:    begin anode = 4'b1011; scan_digit = sec_tens;  end
      2'd2:    begin anode = 4'b1101; scan_digit = sec_units; end
      default: begin anode = 4'b1110; scan_digit = tenths;    end
    endcase
  end

  one_digit_lit: assert property (
    @(posedge clock) disable iff (!arst_n) $onehot(~anode)
  );

  // Digit held for the full dwell
  anode_held_in_dwell: assert property (
    @(posedge clock) disable iff (!arst_n) !dwell_done |=> $stable(anode)
  );

endmodule

/* rtl/stopwatch_top.sv */
`timescale 1ns/1ps

module stopwatch_top import stopwatch_pkg::*; #(
  parameter int TICK_DIV = 5_000_000,
  parameter int SCAN_DIV = 50_000
) (
  input  logic   clock,
  input  logic   arst_n,
  input  logic   up,
  input  logic   clr,
  input  logic   enable,
  output anode_t anode,
  output seg_t   segment
);

  logic tick;
  bcd_t min_digit;
  bcd_t sec_tens;
  bcd_t sec_units;
  bcd_t tenths;
  bcd_t scan_digit;

  ////////////////////
  // Time base and counters
  ////////////////////

  tick_divider #(.TICK_DIV(TICK_DIV)) u_tick_divider (
    .clock  (clock),
    .arst_n (arst_n),
    .enable (enable),
    .clr    (clr),
    .tick   (tick)
  );

  stopwatch_core u_core (
    .clock     (clock),
    .arst_n    (arst_n),
    .clr       (clr),
    .tick      (tick),
    .up        (up),
    .min_digit (min_digit),
    .sec_tens  (sec_tens),
    .sec_units (sec_units),
    .tenths    (tenths)
  );

  ////////////////////
  // Display
  ////////////////////

  display_scan #(.SCAN_DIV(SCAN_DIV)) u_display_scan (
    .clock      (clock),
    .arst_n     (arst_n),
    .min_digit  (min_digit),
    .sec_tens   (sec_tens),
    .sec_units  (sec_units),
    .tenths     (tenths),
    .anode      (anode),
    .scan_digit (scan_digit)
  );

  seg7_decoder u_seg7_decoder (
    .digit   (scan_digit),
    .segment (segment)
  );

endmodule

/* tb/tb_stopwatch.sv */
`timescale 1ns/1ps

module tb_stopwatch import stopwatch_pkg::*; ();

  localparam int TICK_DIV    = 4;
  localparam int SCAN_DIV    = 2;
  localparam int CYCLE_LIMIT = 20_000;
  localparam int READ_WAIT   = 8 * SCAN_DIV + 4;

  logic   clock = 1'b0;
  logic   arst_n;
  logic   up;
  logic   clr;
  logic   enable;
  anode_t anode;
  seg_t   segment;

  int     cycles    = 0;
  int     errors    = 0;
  int     tests_ok  = 0;
  int     tests_bad = 0;
  integer seed      = 84;
  int     model_t   = 0;
  int     div_rem   = 0;
  int     shown [4];

  // Lit segments per digit, bit 0 is a
  seg_t   lit_mask [10] = '{7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
                            7'b1101101, 7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111};
  anode_t scan_order [4] = '{4'b0111, 4'b1011, 4'b1101, 4'b1110};
  string  digit_name [4] = '{"min_digit", "sec_tens", "sec_units", "tenths"};

  stopwatch_top #(.TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV)) u_stopwatch_top (
    .clock   (clock),
    .arst_n  (arst_n),
    .up      (up),
    .clr     (clr),
    .enable  (enable),
    .anode   (anode),
    .segment (segment)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // Model and display reading
  ////////////////////

  // Modulo 6000 tenths in either direction
  function automatic int next_time(input int t, input logic dir);
    if (dir) return (t + 1) % 6000;
    return (t + 5999) % 6000;
  endfunction

  function automatic int expected_digit(input int t, input int idx);
    case (idx)
      0:       return t / 600;
      1:       return (t % 600) / 100;
      2:       return (t % 100) / 10;
      default: return t % 10;
    endcase
  endfunction

  function automatic int seg_to_digit(input seg_t seg);
    for (int d = 0; d < 10; d++) begin
      if (seg == ~lit_mask[d]) return d;
    end
    return -1;
  endfunction

  // One enabled clock, tick on every TICK_DIV-th
  task automatic step_model(input logic dir);
    div_rem = div_rem + 1;
    if (div_rem == TICK_DIV) begin
      div_rem = 0;
      model_t = next_time(model_t, dir);
    end
  endtask

  task automatic count_clocks(input int n, input logic dir);
    @(posedge clock);
    up     <= dir;
    enable <= 1'b1;
    repeat (n) begin
      @(posedge clock);
      step_model(dir);
    end
    enable <= 1'b0;
  endtask

  task automatic pulse_clr();
    @(posedge clock);
    clr <= 1'b1;
    @(posedge clock);
    clr <= 1'b0;
    model_t = 0;
    div_rem = 0;
  endtask

  task automatic read_display();
    int waited;
    @(posedge clock);
    enable <= 1'b0;
    for (int i = 0; i < DIGIT_COUNT; i++) begin
      waited = 0;
      @(negedge clock);
      while (anode != scan_order[i] && waited < READ_WAIT) begin
        @(negedge clock);
        waited++;
      end
      if (anode != scan_order[i]) begin
        $display("%0t: anode pattern %b never came up while reading", $time, scan_order[i]);
        errors++;
        shown[i] = -1;
      end else begin
        shown[i] = seg_to_digit(segment);
        if (shown[i] < 0) begin
          $display("%0t: segment pattern %b on %s is no decimal digit", $time, segment,
                   digit_name[i]);
          errors++;
        end
      end
    end
  endtask

  task automatic check_time();
    int exp_digit;
    read_display();
    for (int i = 0; i < DIGIT_COUNT; i++) begin
      exp_digit = expected_digit(model_t, i);
      if (shown[i] >= 0 && shown[i] != exp_digit) begin
        $display("[FAIL] %0t %s expected %0d got %0d", $time, digit_name[i], exp_digit,
                 shown[i]);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: FAILED with %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic reset_state();
    int     errs;
    int     changes;
    int     pos;
    anode_t prev;
    errs    = errors;
    changes = 0;
    pos     = 0;
    @(negedge clock);
    if (anode != 4'b0111) begin
      $display("[FAIL] %0t anode expected 0111 got %b", $time, anode);
      errors++;
    end
    prev = anode;
    repeat (8 * SCAN_DIV) begin
      @(negedge clock);
      if ($countones(~anode) != 1) begin
        $display("[FAIL] %0t anode expected one low bit got %b", $time, anode);
        errors++;
      end
      if (anode != prev) begin
        pos = (pos + 1) % DIGIT_COUNT;
        if (anode != scan_order[pos]) begin
          $display("[FAIL] %0t anode expected %b got %b", $time, scan_order[pos], anode);
          errors++;
        end
        changes++;
        prev = anode;
      end
    end
    if (changes < DIGIT_COUNT) begin
      $display("%0t: anode did not cycle through all digits after reset", $time);
      errors++;
    end
    check_time();
    report_test("reset", errs);
  endtask

  task automatic count_up();
    int errs;
    errs = errors;
    count_clocks(23 * TICK_DIV, 1'b1);
    check_time();
    report_test("up counting", errs);
  endtask

  // 0:59.9 then 1:00.0
  task automatic carry_through_minute();
    int errs;
    errs = errors;
    count_clocks((599 - model_t) * TICK_DIV - div_rem, 1'b1);
    check_time();
    count_clocks(TICK_DIV, 1'b1);
    check_time();
    report_test("carries", errs);
  endtask

  task automatic pause_and_resume();
    int errs;
    errs = errors;
    count_clocks(TICK_DIV + 2, 1'b1);
    check_time();
    repeat (50 * TICK_DIV) @(posedge clock);
    check_time();
    // Held remainder makes this two ticks
    count_clocks(2 * TICK_DIV - 1, 1'b1);
    check_time();
    report_test("pause", errs);
  endtask

  task automatic count_down_through_zero();
    int errs;
    int len;
    errs = errors;
    pulse_clr();
    count_clocks(30 * TICK_DIV + 1, 1'b1);
    repeat (3) begin
      len = 1 + (($random(seed) & 32'h7fff_ffff) % 40);
      count_clocks(len, 1'b0);
      check_time();
    end
    count_clocks((model_t + 1) * TICK_DIV - div_rem, 1'b0);
    check_time();
    count_clocks(TICK_DIV, 1'b0);
    check_time();
    report_test("down counting", errs);
  endtask

  task automatic clear_while_counting();
    int errs;
    errs = errors;
    @(posedge clock);
    up     <= 1'b1;
    enable <= 1'b1;
    repeat (3 * TICK_DIV + 1) begin
      @(posedge clock);
      step_model(1'b1);
    end
    clr <= 1'b1;
    @(posedge clock);
    clr     <= 1'b0;
    enable  <= 1'b0;
    model_t = 0;
    div_rem = 0;
    check_time();
    count_clocks(TICK_DIV - 1, 1'b1);
    check_time();
    count_clocks(1, 1'b1);
    check_time();
    report_test("clear", errs);
  endtask

  initial begin
    arst_n <= 1'b0;
    up     <= 1'b0;
    clr    <= 1'b0;
    enable <= 1'b0;
    repeat (8) @(posedge clock);
    arst_n <= 1'b1;
    reset_state();
    count_up();
    carry_through_minute();
    pause_and_resume();
    count_down_through_zero();
    clear_while_counting();
    $display("Tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/stopwatch_pkg.sv
rtl/tick_divider.sv
rtl/bcd_digit_counter.sv
rtl/stopwatch_core.sv
rtl/seg7_decoder.sv
rtl/display_scan.sv
rtl/stopwatch_top.sv
tb/tb_stopwatch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the stopwatch testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_stopwatch -f sim.f -o tb_stopwatch \
  && ./obj_dir/tb_stopwatch | tee /dev/stderr | grep "Simulation passed" > /dev/null \
  && echo "Result: PASS" \
  || { echo "Result: FAIL"; exit 1; }
